/* car_game_pkg.sv */
package car_game_pkg;

	// ------------------------------------------------------------------
	// Screen types
	// ------------------------------------------------------------------
	// One LED row, bit 7 is the leftmost column
	typedef logic [7:0] row_t;
	// Entry 0 is the top row
	typedef row_t [0:7] frame_t;

	typedef enum logic [1:0] {
		show_init,
		playing,
		show_end
	} game_state_t;

	// MAX7219 command word, sent raw or built as address over data
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [7:0] addr;
			logic [7:0] data;
		} field;
	} max_word_u;

	// ------------------------------------------------------------------
	// Timing, short enough for simulation
	// ------------------------------------------------------------------
	localparam int STEP_CYCLES = 4096;
	localparam int DEBOUNCE_CYCLES = 8;
	localparam int SCLK_HALF = 2;
	localparam int GAME_STEPS = 24;

	localparam int STEP_W = $clog2(STEP_CYCLES);
	localparam int DEBOUNCE_W = $clog2(DEBOUNCE_CYCLES);
	localparam int SCLK_W = $clog2(SCLK_HALF);
	localparam int PROGRESS_W = $clog2(GAME_STEPS + 1);
	localparam int TABLE_W = 4;
	localparam int WORD_BITS = $bits(max_word_u);
	localparam int HALF_W = $clog2(2 * WORD_BITS + 1);

	// Terminal counts
	localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(STEP_CYCLES - 1);
	localparam logic [DEBOUNCE_W-1:0] DEBOUNCE_LAST = DEBOUNCE_W'(DEBOUNCE_CYCLES - 1);
	localparam logic [SCLK_W-1:0] SCLK_LAST = SCLK_W'(SCLK_HALF - 1);
	localparam logic [PROGRESS_W-1:0] LAST_PROGRESS = PROGRESS_W'(GAME_STEPS - 1);
	// Two half periods per bit on the serial clock
	localparam logic [HALF_W-1:0] HALF_START = HALF_W'(2 * WORD_BITS);

	// ------------------------------------------------------------------
	// MAX7219 registers and word slots
	// ------------------------------------------------------------------
	localparam logic [7:0] REG_DECODE = 8'h09;
	localparam logic [7:0] REG_INTENSITY = 8'h0A;
	localparam logic [7:0] REG_SCAN_LIMIT = 8'h0B;
	localparam logic [7:0] REG_SHUTDOWN = 8'h0C;
	localparam logic [3:0] INTENSITY = 4'd10;
	// Slots 0 to 3 carry setup, 4 to 11 the digits
	localparam logic [3:0] SLOT_DIGIT0 = 4'd4;
	localparam logic [3:0] SLOT_LAST = 4'd11;

	// ------------------------------------------------------------------
	// Game content
	// ------------------------------------------------------------------
	localparam row_t CAR_START = 8'b0001_0000;

	// Blank odd entries keep a gap between obstacles
	localparam row_t OBSTACLE_TABLE [16] = '{
		8'h18, 8'h00, 8'hE0, 8'h00, 8'h07, 8'h00, 8'h3C, 8'h00,
		8'hC3, 8'h00, 8'h0F, 8'h00, 8'hF0, 8'h00, 8'h66, 8'h00
	};

	// Little car, top row first
	localparam frame_t INIT_SCREEN = '{
		8'h18, 8'h3C, 8'h7E, 8'h5A, 8'h7E, 8'h7E, 8'h24, 8'h66
	};
	// Sad face
	localparam frame_t END_SCREEN = '{
		8'h00, 8'h66, 8'h66, 8'h00, 8'h3C, 8'h42, 8'h81, 8'h00
	};

endpackage

/* game_bus_if.sv */
`timescale 1ns/1ps

interface game_bus_if;

	// Main FSM state
	car_game_pkg::game_state_t state;
	// One clock per scroll step
	logic step;
	// Obstacle rows, row 7 sits on the car line
	car_game_pkg::frame_t rows;
	// One-hot car position on the bottom row
	car_game_pkg::row_t car_row;
	// Car overlaps an obstacle, combinational
	logic crash;

	modport sequencer (
		output state,
		output step,
		input crash
	);

	modport scroller (
		input state,
		input step,
		output rows
	);

	modport car (
		input state,
		input rows,
		output car_row,
		output crash
	);

	modport view (
		input state,
		input rows,
		input car_row
	);

endinterface

/* button_debounce.sv */
`timescale 1ns/1ps

module button_debounce (
	input logic clock_50,
	input logic arst_n,
	input logic btn_n,
	output logic pressed
);

	// Two-flop synchronizer, idle high
	logic [1:0] sync;
	// Accepted button level, still active low
	logic level;
	// Clocks the new level has been stable
	logic [car_game_pkg::DEBOUNCE_W-1:0] count;

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			sync <= 2'b11;
			level <= 1'b1;
			count <= '0;
		end else begin
			sync <= {sync[0], btn_n};
			if (sync[1] == level) begin
				// Bounce back, start over
				count <= '0;
			end else if (count == car_game_pkg::DEBOUNCE_LAST) begin
				level <= sync[1];
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// Active high toward the game
	assign pressed = ~level;

endmodule

/* game_sequencer.sv */
`timescale 1ns/1ps

module game_sequencer (
	input logic clock_50,
	input logic arst_n,
	input logic start,
	game_bus_if.sequencer bus
);

	logic start_q;
	logic start_rise;
	// Clocks since last scroll step
	logic [car_game_pkg::STEP_W-1:0] timer;
	// Steps taken in this game
	logic [car_game_pkg::PROGRESS_W-1:0] progress;
	logic last_step;

	// Only a fresh press counts, a held button does nothing
	assign start_rise = start & ~start_q;
	// Step that finishes the table run
	assign last_step = bus.step && (progress == car_game_pkg::LAST_PROGRESS);

	// ------------------------------------------------------------------
	// Main FSM
	// ------------------------------------------------------------------
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			bus.state <= car_game_pkg::show_init;
			start_q <= 1'b0;
		end else begin
			start_q <= start;
			case (bus.state)
				car_game_pkg::show_init: begin
					if (start_rise) begin
						bus.state <= car_game_pkg::playing;
					end
				end
				car_game_pkg::playing: begin
					// Crash or survived every step
					if (bus.crash || last_step) begin
						bus.state <= car_game_pkg::show_end;
					end
				end
				car_game_pkg::show_end: begin
					if (start_rise) begin
						bus.state <= car_game_pkg::show_init;
					end
				end
				default: begin
					bus.state <= car_game_pkg::show_init;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Step timer and progress
	// ------------------------------------------------------------------
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			timer <= '0;
			progress <= '0;
			bus.step <= 1'b0;
		end else if (bus.state != car_game_pkg::playing) begin
			// Fresh count for the next game
			timer <= '0;
			progress <= '0;
			bus.step <= 1'b0;
		end else begin
			bus.step <= (timer == car_game_pkg::STEP_LAST);
			if (timer == car_game_pkg::STEP_LAST) begin
				timer <= '0;
			end else begin
				timer <= timer + 1'b1;
			end
			if (bus.step) begin
				progress <= progress + 1'b1;
			end
		end
	end

endmodule

/* obstacle_scroller.sv */
`timescale 1ns/1ps

module obstacle_scroller (
	input logic clock_50,
	input logic arst_n,
	game_bus_if.scroller bus
);

	// Next table entry to feed in
	logic [car_game_pkg::TABLE_W-1:0] index;
	car_game_pkg::row_t next_row;

	assign next_row = car_game_pkg::OBSTACLE_TABLE[index];

	// ------------------------------------------------------------------
	// Row shift register
	// ------------------------------------------------------------------
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			index <= '0;
			bus.rows <= '0;
		end else if (bus.state != car_game_pkg::playing) begin
			// Empty road when play begins
			index <= '0;
			bus.rows <= '0;
		end else if (bus.step) begin
			// New row on top, everything else moves down
			// Row 7 drops off the bottom
			bus.rows <= {next_row, bus.rows[0:6]};
			// Index wraps, table repeats
			index <= index + 1'b1;
		end
	end

endmodule

/* car_control.sv */
`timescale 1ns/1ps

module car_control (
	input logic clock_50,
	input logic arst_n,
	input logic left,
	input logic right,
	game_bus_if.car bus
);

	logic left_q;
	logic right_q;
	logic left_rise;
	logic right_rise;

	// One column per press
	assign left_rise = left & ~left_q;
	assign right_rise = right & ~right_q;

	// ------------------------------------------------------------------
	// Car position
	// ------------------------------------------------------------------
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			left_q <= 1'b0;
			right_q <= 1'b0;
			bus.car_row <= car_game_pkg::CAR_START;
		end else begin
			left_q <= left;
			right_q <= right;
			if (bus.state != car_game_pkg::playing) begin
				// Park at start column between games
				bus.car_row <= car_game_pkg::CAR_START;
			end else if (left_rise && !bus.car_row[7]) begin
				// Bit 7 is the left edge
				bus.car_row <= bus.car_row << 1;
			end else if (right_rise && !bus.car_row[0]) begin
				bus.car_row <= bus.car_row >> 1;
			end
		end
	end

	// Hit when the car shares a lit column with the bottom row
	assign bus.crash = |(bus.car_row & bus.rows[7]);

endmodule

/* frame_compose.sv */
`timescale 1ns/1ps

module frame_compose (
	game_bus_if.view bus,
	input logic [2:0] digit,
	output car_game_pkg::row_t column
);

	car_game_pkg::frame_t play_frame;
	// Frame currently on the matrix
	car_game_pkg::frame_t shown;

	// Road with the car merged into the bottom row
	always_comb begin
		play_frame = bus.rows;
		play_frame[7] = bus.rows[7] | bus.car_row;
	end

	// Screen select by game state
	always_comb begin
		case (bus.state)
			car_game_pkg::playing: shown = play_frame;
			car_game_pkg::show_end: shown = car_game_pkg::END_SCREEN;
			default: shown = car_game_pkg::INIT_SCREEN;
		endcase
	end

	// ------------------------------------------------------------------
	// Transpose, one screen column per MAX7219 digit
	// ------------------------------------------------------------------
	// Top row lands in data bit 7
	always_comb begin
		for (int r = 0; r < 8; r++) begin
			column[7 - r] = shown[r][3'd7 - digit];
		end
	end

endmodule

/* max7219_driver.sv */
`timescale 1ns/1ps

module max7219_driver (
	input logic clock_50,
	input logic arst_n,
	input car_game_pkg::row_t column,
	output logic [2:0] digit,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	// Half period prescaler for the serial clock
	logic [car_game_pkg::SCLK_W-1:0] tick;
	logic tick_end;
	// Word slot, setup first then digits forever
	logic [3:0] slot;
	logic [3:0] digit_slot;
	// Half periods left in the current word
	logic [car_game_pkg::HALF_W-1:0] half;
	logic [15:0] shreg;
	car_game_pkg::max_word_u word;

	assign tick_end = (tick == car_game_pkg::SCLK_LAST);
	assign digit_slot = slot - car_game_pkg::SLOT_DIGIT0;
	assign digit = digit_slot[2:0];

	// ------------------------------------------------------------------
	// Word builder
	// ------------------------------------------------------------------
	always_comb begin
		word.raw = '0;
		case (slot)
			4'd0: begin
				// No BCD decode, raw segments
				word.field.addr = car_game_pkg::REG_DECODE;
				word.field.data = 8'h00;
			end
			4'd1: begin
				// All eight digits scanned
				word.field.addr = car_game_pkg::REG_SCAN_LIMIT;
				word.field.data = 8'h07;
			end
			4'd2: begin
				word.field.addr = car_game_pkg::REG_INTENSITY;
				word.field.data = {4'h0, car_game_pkg::INTENSITY};
			end
			4'd3: begin
				// Leave shutdown mode
				word.field.addr = car_game_pkg::REG_SHUTDOWN;
				word.field.data = 8'h01;
			end
			default: begin
				// Digit registers start at address 1
				word.field.addr = {5'd0, digit} + 8'd1;
				word.field.data = column;
			end
		endcase
	end

	// ------------------------------------------------------------------
	// Serial shifter
	// ------------------------------------------------------------------
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			tick <= '0;
			slot <= '0;
			half <= '0;
			shreg <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
		end else begin
			if (tick_end) begin
				tick <= '0;
			end else begin
				tick <= tick + 1'b1;
			end
			if (tick_end) begin
				if (max7219_ncs) begin
					// Gap over, select chip with MSB on din
					shreg <= word.raw;
					half <= car_game_pkg::HALF_START;
					max7219_ncs <= 1'b0;
				end else if (half == '0) begin
					// Rising ncs latches the word
					max7219_ncs <= 1'b1;
					if (slot == car_game_pkg::SLOT_LAST) begin
						slot <= car_game_pkg::SLOT_DIGIT0;
					end else begin
						slot <= slot + 1'b1;
					end
				end else begin
					half <= half - 1'b1;
					max7219_clk <= ~max7219_clk;
					// Next bit on the falling edge
					if (max7219_clk) begin
						shreg <= shreg << 1;
					end
				end
			end
		end
	end

	assign max7219_din = shreg[15];

endmodule

/* car_game_top.sv */
`timescale 1ns/1ps

module car_game_top (
	input logic clock_50,
	input logic arst_n,
	input logic start_btn_n,
	input logic left_btn_n,
	input logic right_btn_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	// Debounced active-high buttons
	logic start;
	logic left;
	logic right;
	// Digit index and column byte between driver and frame logic
	logic [2:0] digit;
	car_game_pkg::row_t column;

	game_bus_if bus ();

	// ------------------------------------------------------------------
	// Buttons
	// ------------------------------------------------------------------
	button_debounce start_debounce_i (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.btn_n    (start_btn_n),
		.pressed  (start)
	);

	button_debounce left_debounce_i (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.btn_n    (left_btn_n),
		.pressed  (left)
	);

	button_debounce right_debounce_i (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.btn_n    (right_btn_n),
		.pressed  (right)
	);

	// ------------------------------------------------------------------
	// Game
	// ------------------------------------------------------------------
	game_sequencer game_sequencer_i (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.start    (start),
		.bus      (bus.sequencer)
	);

	obstacle_scroller obstacle_scroller_i (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.bus      (bus.scroller)
	);

	car_control car_control_i (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.left     (left),
		.right    (right),
		.bus      (bus.car)
	);

	// ------------------------------------------------------------------
	// Display
	// ------------------------------------------------------------------
	frame_compose frame_compose_i (
		.bus    (bus.view),
		.digit  (digit),
		.column (column)
	);

	max7219_driver max7219_driver_i (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.column      (column),
		.digit       (digit),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// 10 ns period, 100 MHz stand-in for the board clock
	initial begin
		clk = 1'b0;
	end

	always begin
		#5 clk = ~clk;
	end

endmodule

/* car_game_chk.sv */
`timescale 1ns/1ps

module car_game_chk (
	input logic clock_50,
	input logic arst_n,
	input logic max7219_ncs,
	input logic max7219_clk,
	input logic step,
	input car_game_pkg::game_state_t state
);

	// Failed assertions, read by the testbench verdict
	int fails = 0;

	// Serial clock only toggles inside a selected word
	sclk_inside_word: assert property (
		@(posedge clock_50) disable iff (!arst_n)
		max7219_clk |-> !max7219_ncs
	) else begin
		fails++;
		$error("serial clock high while chip select is idle");
	end

	// Scroll step is a single clock pulse
	step_one_clock: assert property (
		@(posedge clock_50) disable iff (!arst_n)
		step |=> !step
	) else begin
		fails++;
		$error("step held for more than one clock");
	end

	// The game has to be played before the end screen
	no_init_to_end: assert property (
		@(posedge clock_50) disable iff (!arst_n)
		(state == car_game_pkg::show_init) |=> (state != car_game_pkg::show_end)
	) else begin
		fails++;
		$error("state jumped from init screen to end screen");
	end

endmodule

bind car_game_top car_game_chk car_game_chk_i (
	.clock_50    (clock_50),
	.arst_n      (arst_n),
	.max7219_ncs (max7219_ncs),
	.max7219_clk (max7219_clk),
	.step        (bus.step),
	.state       (bus.state)
);

/* car_game_tb.sv */
`timescale 1ns/1ps

module car_game_tb;

	// Clocks allowed for one serial word, one word is 68 clocks
	localparam int WORD_WAIT = 200;
	localparam int SYNC_WORDS = 10;
	// Frames allowed before a scroll step shows up
	localparam int CHANGE_FRAMES = 20;
	localparam int HOLD_CYCLES = 20;

	logic clock_50;
	logic arst_n;
	logic start_btn_n;
	logic left_btn_n;
	logic right_btn_n;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;

	int word_errors;
	int frame_errors;
	int fault_errors;
	int assert_errors;

	// Road model, row 0 on top
	car_game_pkg::frame_t model_rows;
	int table_idx;
	// Car bit index, 7 is the left edge
	int car_pos;

	tb_clock tb_clock_i (.clk(clock_50));

	car_game_top car_game_top_i (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.start_btn_n (start_btn_n),
		.left_btn_n  (left_btn_n),
		.right_btn_n (right_btn_n),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

	// ------------------------------------------------------------------
	// Compare tasks and expected values
	// ------------------------------------------------------------------
	task automatic check_word(input string name, input car_game_pkg::max_word_u got,
			input car_game_pkg::max_word_u exp);
		if (got !== exp) begin
			word_errors++;
			$display("MISMATCH %s: got %h expected %h", name, got.raw, exp.raw);
		end
	endtask

	task automatic check_frame(input string name, input car_game_pkg::frame_t got,
			input car_game_pkg::frame_t exp);
		for (int r = 0; r < 8; r++) begin
			if (got[r] !== exp[r]) begin
				frame_errors++;
				$display("MISMATCH %s row %0d: got %h expected %h", name, r, got[r], exp[r]);
			end
		end
	endtask

	function automatic car_game_pkg::max_word_u make_word(input logic [7:0] addr,
			input logic [7:0] data);
		car_game_pkg::max_word_u w;
		w.field.addr = addr;
		w.field.data = data;
		return w;
	endfunction

	// Screen column d, top row in bit 7
	function automatic car_game_pkg::row_t column_of(input car_game_pkg::frame_t f, input int d);
		car_game_pkg::row_t c;
		for (int r = 0; r < 8; r++) begin
			c[7 - r] = f[r][7 - d];
		end
		return c;
	endfunction

	function automatic car_game_pkg::frame_t expected_play();
		car_game_pkg::frame_t f;
		f = model_rows;
		f[7] = f[7] | (8'h01 << car_pos);
		return f;
	endfunction

	// New table row on top, bottom row falls off
	task automatic advance_model();
		for (int r = 7; r > 0; r--) begin
			model_rows[r] = model_rows[r - 1];
		end
		model_rows[0] = car_game_pkg::OBSTACLE_TABLE[table_idx];
		table_idx = (table_idx + 1) % 16;
	endtask

	task automatic reset_model();
		model_rows = '0;
		table_idx = 0;
		car_pos = 4;
	endtask

	// ------------------------------------------------------------------
	// Serial decoder
	// ------------------------------------------------------------------
	// Starts at the next falling ncs, ends at its rising edge
	task automatic read_word(output car_game_pkg::max_word_u w);
		int n;
		int bits;
		logic started;
		logic done;
		logic prev_clk;
		logic prev_ncs;
		w = '0;
		n = 0;
		bits = 0;
		started = 1'b0;
		done = 1'b0;
		prev_clk = max7219_clk;
		prev_ncs = max7219_ncs;
		while (!done && n < WORD_WAIT) begin
			@(negedge clock_50);
			n++;
			if (prev_ncs && !max7219_ncs) begin
				started = 1'b1;
				bits = 0;
				n = 0;
			end
			// Din is stable on the rising serial clock
			if (started && max7219_clk && !prev_clk) begin
				w.raw = {w.raw[14:0], max7219_din};
				bits++;
			end
			if (started && !prev_ncs && max7219_ncs) begin
				done = 1'b1;
			end
			prev_clk = max7219_clk;
			prev_ncs = max7219_ncs;
		end
		if (!done) begin
			fault_errors++;
			$display("Timed out waiting for a serial word from the display driver");
		end else if (bits != 16) begin
			fault_errors++;
			$display("Serial word had %0d clock pulses instead of 16", bits);
		end
	endtask

	// Digits 1 to 8 in a row, transposed back into screen rows
	task automatic read_frame(output car_game_pkg::frame_t f);
		car_game_pkg::max_word_u w;
		int n;
		f = '0;
		n = 0;
		read_word(w);
		while (w.field.addr != 8'd1 && n < SYNC_WORDS) begin
			read_word(w);
			n++;
		end
		if (w.field.addr != 8'd1) begin
			fault_errors++;
			$display("Never saw digit 1 in the refresh sequence");
		end
		for (int d = 0; d < 8; d++) begin
			if (d > 0) begin
				read_word(w);
				check_word("digit address", w, make_word(8'(d + 1), w.field.data));
			end
			for (int r = 0; r < 8; r++) begin
				f[r][7 - d] = w.field.data[7 - r];
			end
		end
	endtask

	// First differing frame may be torn, the one after it is clean
	task automatic wait_change(input car_game_pkg::frame_t prev,
			output car_game_pkg::frame_t got);
		car_game_pkg::frame_t f;
		int n;
		logic changed;
		n = 0;
		changed = 1'b0;
		got = prev;
		while (!changed && n < CHANGE_FRAMES) begin
			read_frame(f);
			n++;
			changed = (f !== prev);
		end
		if (changed) begin
			read_frame(got);
		end else begin
			fault_errors++;
			$display("Timed out waiting for the displayed frame to change");
		end
	endtask

	// ------------------------------------------------------------------
	// Buttons
	// ------------------------------------------------------------------
	task automatic set_button(input int which, input logic level);
		case (which)
			0: start_btn_n = level;
			1: left_btn_n = level;
			default: right_btn_n = level;
		endcase
	endtask

	// Held and released 20 clocks each
	task automatic press(input int which, input int times);
		repeat (times) begin
			@(posedge clock_50);
			#1 set_button(which, 1'b0);
			repeat (HOLD_CYCLES) @(posedge clock_50);
			#1 set_button(which, 1'b1);
			repeat (HOLD_CYCLES) @(posedge clock_50);
		end
	endtask

	// Car saturates at both edges
	task automatic move_car(input logic to_left, input int n);
		for (int i = 0; i < n; i++) begin
			press(to_left ? 1 : 2, 1);
			if (to_left && car_pos < 7) begin
				car_pos++;
			end else if (!to_left && car_pos > 0) begin
				car_pos--;
			end
		end
	endtask

	// Dodge whatever reaches the car line on the next step
	task automatic dodge(inout car_game_pkg::frame_t prev);
		car_game_pkg::row_t next;
		logic found;
		next = model_rows[6];
		found = 1'b0;
		if (next[car_pos]) begin
			for (int d = 1; d < 8 && !found; d++) begin
				if (car_pos + d <= 7 && !next[car_pos + d]) begin
					move_car(1'b1, d);
					found = 1'b1;
				end else if (car_pos - d >= 0 && !next[car_pos - d]) begin
					move_car(1'b0, d);
					found = 1'b1;
				end
			end
			read_frame(prev);
			check_frame("frame after dodge", prev, expected_play());
		end
	endtask

	// ------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------
	task automatic test_config_sequence();
		car_game_pkg::max_word_u w;
		read_word(w);
		check_word("decode word", w, make_word(car_game_pkg::REG_DECODE, 8'h00));
		read_word(w);
		check_word("scan limit word", w, make_word(car_game_pkg::REG_SCAN_LIMIT, 8'h07));
		read_word(w);
		check_word("intensity word", w,
			make_word(car_game_pkg::REG_INTENSITY, {4'h0, car_game_pkg::INTENSITY}));
		read_word(w);
		check_word("shutdown word", w, make_word(car_game_pkg::REG_SHUTDOWN, 8'h01));
		// Two refresh rounds of the init image
		for (int i = 0; i < 16; i++) begin
			read_word(w);
			check_word("refresh word", w,
				make_word(8'(i % 8 + 1), column_of(car_game_pkg::INIT_SCREEN, i % 8)));
		end
	endtask

	task automatic test_init_screen();
		car_game_pkg::frame_t f;
		read_frame(f);
		check_frame("init screen", f, car_game_pkg::INIT_SCREEN);
	endtask

	task automatic test_full_game();
		car_game_pkg::frame_t prev;
		car_game_pkg::frame_t got;
		press(0, 1);
		reset_model();
		read_frame(prev);
		check_frame("first play frame", prev, expected_play());
		// Push against the left edge
		move_car(1'b1, 4);
		read_frame(prev);
		check_frame("car at left edge", prev, expected_play());
		for (int s = 1; s < car_game_pkg::GAME_STEPS; s++) begin
			wait_change(prev, got);
			advance_model();
			check_frame($sformatf("step %0d", s), got, expected_play());
			prev = got;
			if (s == 1) begin
				// Push against the right edge
				move_car(1'b0, 8);
				read_frame(prev);
				check_frame("car at right edge", prev, expected_play());
			end
			dodge(prev);
		end
		wait_change(prev, got);
		check_frame("end screen after last step", got, car_game_pkg::END_SCREEN);
	endtask

	task automatic test_crash_restart();
		car_game_pkg::frame_t prev;
		car_game_pkg::frame_t got;
		press(0, 1);
		read_frame(got);
		check_frame("init screen after restart", got, car_game_pkg::INIT_SCREEN);
		press(0, 1);
		reset_model();
		read_frame(prev);
		check_frame("first frame of second game", prev, expected_play());
		// Car stays put under the first obstacle
		for (int s = 1; s < 8; s++) begin
			wait_change(prev, got);
			advance_model();
			check_frame($sformatf("second game step %0d", s), got, expected_play());
			prev = got;
		end
		wait_change(prev, got);
		check_frame("end screen after crash", got, car_game_pkg::END_SCREEN);
		press(0, 1);
		read_frame(got);
		check_frame("init screen after crash", got, car_game_pkg::INIT_SCREEN);
	endtask

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial begin
		arst_n = 1'b0;
		start_btn_n = 1'b1;
		left_btn_n = 1'b1;
		right_btn_n = 1'b1;
		word_errors = 0;
		frame_errors = 0;
		fault_errors = 0;
		reset_model();
		repeat (16) @(posedge clock_50);
		#1 arst_n = 1'b1;
		test_config_sequence();
		test_init_screen();
		test_full_game();
		test_crash_restart();
		assert_errors = car_game_top_i.car_game_chk_i.fails;
		$display("errors: word %0d frame %0d other %0d assertion %0d",
			word_errors, frame_errors, fault_errors, assert_errors);
		if (word_errors + frame_errors + fault_errors + assert_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* all.f */
car_game_pkg.sv
game_bus_if.sv
button_debounce.sv
game_sequencer.sv
obstacle_scroller.sv
car_control.sv
frame_compose.sv
max7219_driver.sv
car_game_top.sv
tb_clock.sv
car_game_chk.sv
car_game_tb.sv
